// File: source/cordic_defines.svh
`ifndef CORDIC_DEFINES_SVH
`define CORDIC_DEFINES_SVH

// word layout of every x, y and z value
`define CORDIC_WIDTH 32 // full data word
`define CORDIC_FRAC 16  // Q16.16 fraction bits

// one registered stage per micro-rotation
`define CORDIC_ITERATIONS 16

`endif

// File: source/cordic_types_pkg.sv
`include "cordic_defines.svh"

package cordic_types_pkg;

    typedef logic signed [`CORDIC_WIDTH-1:0] fixed_t; // Q16.16

    typedef enum logic {
        op_rotation  = 1'b0, // cos/sin of z
        op_vectoring = 1'b1  // magnitude and angle of (x, y)
    } cordic_op_e;

    typedef enum logic {
        fold_none   = 1'b0,
        fold_negate = 1'b1  // angle was moved by pi
    } cordic_fold_e;

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } cordic_vec_t;

    typedef struct packed {
        logic         valid;
        cordic_op_e   op;
        cordic_fold_e fold;
        cordic_vec_t  vec;
    } cordic_slot_t;

endpackage

// File: source/cordic_math_pkg.sv
package cordic_math_pkg;

    import cordic_types_pkg::*;

    localparam fixed_t k_inv_circular = 39797; // 1/1.64676 in Q16.16

    // rotation angles beyond +-pi/2 are moved by pi
    localparam fixed_t half_pi = 102944;
    localparam fixed_t pi_q    = 205887;

    // atan(2^-index) in Q16.16
    function automatic fixed_t atan_angle(input int index);
        fixed_t angle;
        case (index)
            0:       angle = 51472; // pi/4
            1:       angle = 30386;
            2:       angle = 16055;
            3:       angle = 8150;
            4:       angle = 4091;
            5:       angle = 2047;
            6:       angle = 1024;
            7:       angle = 512;
            8:       angle = 256;
            9:       angle = 128;
            10:      angle = 64;
            11:      angle = 32;
            12:      angle = 16;
            13:      angle = 8;
            14:      angle = 4;
            15:      angle = 2;
            default: angle = '0; // below one LSB
        endcase
        return angle;
    endfunction

endpackage

// File: source/cordic_prescale.sv
`timescale 1ns/1ps

module cordic_prescale (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           enable,
    input  cordic_types_pkg::cordic_op_e   op,
    input  cordic_types_pkg::cordic_vec_t  in_vec,
    output cordic_types_pkg::cordic_slot_t slot_out
);
    import cordic_types_pkg::*;
    import cordic_math_pkg::*;

    fixed_t       z_in;
    cordic_vec_t  seed;
    cordic_fold_e fold;

    logic         valid_q;
    cordic_op_e   op_q;
    cordic_fold_e fold_q;
    cordic_vec_t  vec_q;

    assign z_in = in_vec.z;

    // seed vector and two-way angle fold
    always_comb begin
        seed = in_vec; // vectoring uses the input as is
        fold = fold_none;
        if (op == op_rotation) begin
            seed.x = k_inv_circular; // pre-scaled so no gain fix at the end
            seed.y = '0;
            if (z_in > half_pi) begin
                seed.z = z_in - pi_q;
                fold   = fold_negate;
            end else if (z_in < -half_pi) begin
                seed.z = z_in + pi_q;
                fold   = fold_negate;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= enable;
        end
    end

    always_ff @(posedge clk) begin
        op_q   <= op;
        fold_q <= fold;
        vec_q  <= seed;
    end

    assign slot_out = '{valid: valid_q, op: op_q, fold: fold_q, vec: vec_q};

endmodule

// File: source/cordic_stage.sv
`timescale 1ns/1ps

module cordic_stage #(
    parameter int stage_index = 0
) (
    input  logic                           clk,
    input  logic                           rst,
    input  cordic_types_pkg::cordic_slot_t slot_in,
    output cordic_types_pkg::cordic_slot_t slot_out
);
    import cordic_types_pkg::*;
    import cordic_math_pkg::*;

    localparam fixed_t alpha = atan_angle(stage_index); // table angle of this stage

    fixed_t       x_in;
    fixed_t       y_in;
    fixed_t       z_in;
    fixed_t       x_shift;
    fixed_t       y_shift;
    logic         dir_pos;

    logic         valid_q;
    cordic_op_e   op_q;
    cordic_fold_e fold_q;
    cordic_vec_t  vec_q;

    assign x_in    = slot_in.vec.x;
    assign y_in    = slot_in.vec.y;
    assign z_in    = slot_in.vec.z;
    assign x_shift = x_in >>> stage_index;
    assign y_shift = y_in >>> stage_index;

    // rotation drives z to zero, vectoring drives y to zero
    assign dir_pos = (slot_in.op == op_rotation) ? (z_in >= 0) : ((x_in < 0) != (y_in < 0));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= slot_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        op_q   <= slot_in.op;
        fold_q <= slot_in.fold;
        if (dir_pos) begin
            vec_q.x <= x_in - y_shift;
            vec_q.y <= y_in + x_shift;
            vec_q.z <= z_in - alpha;
        end else begin
            vec_q.x <= x_in + y_shift;
            vec_q.y <= y_in - x_shift;
            vec_q.z <= z_in + alpha;
        end
    end

    assign slot_out = '{valid: valid_q, op: op_q, fold: fold_q, vec: vec_q};

endmodule

// File: source/cordic_postscale.sv
`timescale 1ns/1ps

`include "cordic_defines.svh"

module cordic_postscale (
    input  logic                           clk,
    input  logic                           rst,
    input  cordic_types_pkg::cordic_slot_t slot_in,
    output cordic_types_pkg::cordic_vec_t  out_vec,
    output logic                           valid
);
    import cordic_types_pkg::*;
    import cordic_math_pkg::*;

    fixed_t                            x_in;
    fixed_t                            y_in;
    fixed_t                            x_abs;
    logic signed [2*`CORDIC_WIDTH-1:0] product; // full precision
    logic signed [2*`CORDIC_WIDTH-1:0] scaled;
    cordic_vec_t                       result;

    assign x_in  = slot_in.vec.x;
    assign y_in  = slot_in.vec.y;
    assign x_abs = (x_in < 0) ? -x_in : x_in;

    // remove the circular gain from the magnitude
    assign product = x_abs * k_inv_circular;
    assign scaled  = product >>> `CORDIC_FRAC;

    always_comb begin
        result = slot_in.vec; // z is never touched here
        if (slot_in.op == op_vectoring) begin
            result.x = scaled[`CORDIC_WIDTH-1:0];
        end else if (slot_in.fold == fold_negate) begin
            // angle was shifted by pi, so cos and sin flip sign
            result.x = -x_in;
            result.y = -y_in;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_vec <= '0;
            valid   <= 1'b0;
        end else begin
            valid <= slot_in.valid;
            if (slot_in.valid) begin
                out_vec <= result;
            end else begin
                out_vec <= '0; // idle output reads as zero
            end
        end
    end

endmodule

// File: source/cordic_top.sv
`timescale 1ns/1ps

`include "cordic_defines.svh"

module cordic_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enable,
    input  cordic_types_pkg::cordic_op_e  op,
    input  cordic_types_pkg::cordic_vec_t in_vec,
    output cordic_types_pkg::cordic_vec_t out_vec,
    output logic                          valid
);
    import cordic_types_pkg::*;

    cordic_slot_t slot [0:`CORDIC_ITERATIONS]; // slot[i] feeds stage i

    cordic_prescale u_prescale (
        .clk      (clk),
        .rst      (rst),
        .enable   (enable),
        .op       (op),
        .in_vec   (in_vec),
        .slot_out (slot[0])
    );

    for (genvar i = 0; i < `CORDIC_ITERATIONS; i++) begin : g_stage
        cordic_stage #(
            .stage_index (i)
        ) u_stage (
            .clk      (clk),
            .rst      (rst),
            .slot_in  (slot[i]),
            .slot_out (slot[i+1])
        );
    end

    cordic_postscale u_postscale (
        .clk     (clk),
        .rst     (rst),
        .slot_in (slot[`CORDIC_ITERATIONS]),
        .out_vec (out_vec),
        .valid   (valid)
    );

endmodule

// File: tests/cordic_assert.sv
`timescale 1ns/1ps

`include "cordic_defines.svh"

module cordic_assert (
    input logic                          clk,
    input logic                          rst,
    input logic                          enable,
    input logic                          valid,
    input cordic_types_pkg::cordic_vec_t out_vec
);
    localparam int latency = `CORDIC_ITERATIONS + 2; // prescale, stages, postscale

    // every strobe leaves the pipeline exactly once, one full depth later
    a_latency: assert property (@(posedge clk) disable iff (rst)
        valid == $past(enable, latency))
        else $error("valid does not follow enable by %0d cycles", latency);

    a_reset_valid: assert property (@(posedge clk) $fell(rst) |-> !valid)
        else $error("valid is high in the first cycle after reset");

    a_idle_zero: assert property (@(posedge clk) !valid |-> out_vec == '0)
        else $error("out_vec is not zero while valid is low");

endmodule

bind cordic_top cordic_assert u_assert (
    .clk     (clk),
    .rst     (rst),
    .enable  (enable),
    .valid   (valid),
    .out_vec (out_vec)
);

// File: tests/cordic_tb.sv
`timescale 1ns/1ps

`include "cordic_defines.svh"

module cordic_tb;
    import cordic_types_pkg::*;

    localparam int clk_period = 20;
    localparam int latency    = `CORDIC_ITERATIONS + 2;
    localparam int tolerance  = 64; // LSB on each field

    typedef struct packed {
        cordic_op_e  op;
        cordic_vec_t stim;
        cordic_vec_t expect_vec;
        int          gap; // idle cycles before the row
    } row_t;

    typedef struct packed {
        int row_index;
        int start_cycle; // edge at which enable was raised for the row
    } pending_t;

    logic        clk;
    logic        rst;
    logic        enable;
    cordic_op_e  op;
    cordic_vec_t in_vec;
    cordic_vec_t out_vec;
    logic        valid;

    row_t     rows [$];
    pending_t pending [$];
    int       cycle;
    int       checks;
    int       value_errors;
    int       sequence_errors;

    cordic_top dut0 (
        .clk     (clk),
        .rst     (rst),
        .enable  (enable),
        .op      (op),
        .in_vec  (in_vec),
        .out_vec (out_vec),
        .valid   (valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic add_row(input cordic_op_e row_op, input fixed_t xi, input fixed_t yi,
                           input fixed_t zi, input fixed_t xe, input fixed_t ye,
                           input fixed_t ze, input int gap);
        row_t row;
        row.op         = row_op;
        row.stim       = '{x: xi, y: yi, z: zi};
        row.expect_vec = '{x: xe, y: ye, z: ze};
        row.gap        = gap;
        rows.push_back(row);
    endtask

    // expected results from cos, sin, hypot and atan in Q16.16
    task automatic build_table();
        add_row(op_rotation, 0, 0, 0, 65536, 0, 0, 2);              // z = 0
        add_row(op_rotation, 0, 0, 32768, 57514, 31419, 0, 0);      // z = 0.5
        add_row(op_rotation, 0, 0, -78643, 23748, -61082, 0, 0);    // z = -1.2
        add_row(op_rotation, 0, 0, 102944, 0, 65536, 0, 0);         // z = pi/2 just inside
        add_row(op_rotation, 0, 0, 163840, -52504, 39222, 0, 4);    // z = 2.5
        add_row(op_rotation, 0, 0, -183501, -61749, -21954, 0, 0);  // z = -2.8
        add_row(op_rotation, 0, 0, 205887, -65536, 0, 0, 0);        // z = pi
        add_row(op_vectoring, 196608, 262144, 0, 327680, 0, 60771, 0);
        add_row(op_vectoring, 65536, -65536, 16384, 92682, 0, -35088, 3);
        add_row(op_vectoring, 327680, 32768, 0, 329314, 0, 6532, 0);
        add_row(op_rotation, 0, 0, 32768, 57514, 31419, 0, 0);      // right after vectoring
    endtask

    function automatic int total_gaps();
        int sum;
        sum = 0;
        foreach (rows[i]) begin
            sum += rows[i].gap;
        end
        return sum;
    endfunction

    task automatic apply_row(input int index);
        pending_t entry;
        repeat (rows[index].gap) begin
            @(posedge clk);
            enable <= 1'b0;
        end
        @(posedge clk);
        enable <= 1'b1;
        op     <= rows[index].op;
        in_vec <= rows[index].stim;
        entry.row_index   = index;
        entry.start_cycle = cycle + 1; // count of this edge
        pending.push_back(entry);
    endtask

    task automatic compare_field(input int row, input string field, input fixed_t got,
                                 input fixed_t want);
        longint diff;
        diff = longint'(got) - longint'(want);
        if (diff < 0) begin
            diff = -diff;
        end
        if (diff > tolerance) begin
            value_errors++;
            $display("** Error at %0d ns: row %0d field %s is %0d, expected %0d",
                     $time, row, field, got, want);
        end
    endtask

    task automatic check_output();
        pending_t head;
        row_t     row;
        if (!valid) begin
            if (out_vec != '0) begin
                value_errors++;
                $display("** Error at %0d ns: out_vec is %h while valid is low", $time, out_vec);
            end
        end else if (pending.size() == 0) begin
            sequence_errors++;
            $display("At %0d ns valid went high but no sample was in flight", $time);
        end else begin
            head = pending.pop_front();
            row  = rows[head.row_index];
            checks++;
            if (cycle - head.start_cycle != latency) begin
                value_errors++;
                $display("** Error at %0d ns: row %0d latency is %0d cycles, expected %0d",
                         $time, head.row_index, cycle - head.start_cycle, latency);
            end
            compare_field(head.row_index, "x", out_vec.x, row.expect_vec.x);
            compare_field(head.row_index, "y", out_vec.y, row.expect_vec.y); // residual in vectoring
            compare_field(head.row_index, "z", out_vec.z, row.expect_vec.z);
        end
    endtask

    // outputs are stable on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            check_output();
        end
    end

    initial begin
        int drain;
        rst    = 1'b1;
        enable = 1'b0;
        op     = op_rotation;
        in_vec = '0;
        build_table();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end
        @(posedge clk);
        enable <= 1'b0;
        drain = 0;
        while (pending.size() != 0 && drain < latency + 8) begin
            @(posedge clk);
            drain++;
        end
        repeat (4) @(posedge clk); // catch stray valid pulses
        if (pending.size() != 0) begin
            sequence_errors += pending.size();
            $display("%0d expected results never came out of the pipeline", pending.size());
        end
        $display("results checked: %0d, value errors: %0d, sequence errors: %0d",
                 checks, value_errors, sequence_errors);
        if (value_errors + sequence_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        int limit;
        @(negedge rst);
        limit = 20 * (rows.size() + total_gaps() + `CORDIC_ITERATIONS + 10);
        repeat (limit) @(posedge clk);
        $display("Timeout: the run did not finish within %0d clock cycles", limit);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/cordic_types_pkg.sv
source/cordic_math_pkg.sv
source/cordic_prescale.sv
source/cordic_stage.sv
source/cordic_postscale.sv
source/cordic_top.sv
tests/cordic_assert.sv
tests/cordic_tb.sv

// File: run.sh
#!/bin/sh
# build and run the CORDIC testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module cordic_tb -Mdir obj_dir -f vlog.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vcordic_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -qF '*** TEST PASSED ***' "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $log"
    exit 1
fi
